//--- list.f
+incdir+tests
hw/mvsIoPkg.sv
hw/ioAddrDecode.sv
hw/neoF0.sv
hw/rtcCalendar.sv
hw/ledDriver.sv
hw/mvsIoTop.sv
tests/mvsIoTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the I/O controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mvsIoTb -f list.f -o simv

# The simulator exits non-zero on a fatal check, the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation reported errors"
	exit 1
fi

if ! grep -q "Verification passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0

//--- tests/mvsIoChecks.svh
// Calendar model in plain seconds of the day
function automatic int bcdToInt(input logic [7:0] v);
	return int'(v[7:4]) * 10 + int'(v[3:0]);
endfunction

function automatic logic [7:0] intToBcd(input int v);
	return {4'(v / 10), 4'(v % 10)};
endfunction

// Date fields ride along unchanged
function automatic mvsIoPkg::rtcTimeT advanceTime(input mvsIoPkg::rtcTimeT t, input int ticks);
	mvsIoPkg::rtcTimeT r;
	int secs;
	secs = bcdToInt(t.hours) * 3600 + bcdToInt(t.minutes) * 60 + bcdToInt(t.seconds);
	secs = (secs + ticks) % 86400;	// Hours wrap, no day carry
	r = t;
	r.hours = intToBcd(secs / 3600);
	r.minutes = intToBcd(secs / 60 % 60);
	r.seconds = intToBcd(secs % 60);
	return r;
endfunction

function automatic mvsIoPkg::rtcTimeT randomTime();
	mvsIoPkg::rtcTimeT t;
	t.year = intToBcd(int'(nextRand() % 100));
	t.month = 4'(1 + nextRand() % 12);
	t.weekday = 4'(nextRand() % 7);
	t.day = intToBcd(int'(1 + nextRand() % 31));
	t.hours = intToBcd(int'(nextRand() % 24));
	t.minutes = intToBcd(int'(nextRand() % 60));
	t.seconds = intToBcd(int'(nextRand() % 60));
	return t;
endfunction

// Read back may sit one tick either side of the cycle estimate
task automatic checkReadTime(input mvsIoPkg::rtcTimeT written, input mvsIoPkg::rtcTimeT got,
	input int elapsed);
	int ticks;
	int k;
	logic match;
	ticks = elapsed / mvsIoPkg::RTC_TICK_CYCLES;
	match = 1'b0;
	for (k = ticks - 1; k <= ticks + 1; k++)
		if (k >= 0 && got == advanceTime(written, k))
			match = 1'b1;
	if (!match)
		checkEq("rtcTime", {16'h0, got}, {16'h0, advanceTime(written, ticks)});
endtask

task automatic testReset();
	checkEq("dataOutEn", 64'(dataOutEn), 64'(0));
	checkEq("nSlot", 64'(nSlot), 64'(6'b111110));
	checkEq("{slotC,slotB,slotA}", 64'({slotC, slotB, slotA}), 64'(0));
	checkEq("elLamps", 64'(elLamps), 64'(0));
	checkEq("ledMarquee1", 64'(ledMarquee1), 64'(0));
	checkEq("ledMarquee2", 64'(ledMarquee2), 64'(0));
endtask

// Access that must not enable the data bus
task automatic noResponse(input logic [23:0] addr, input logic ldsLevel);
	int i;
	cpuAddr = addr[23:1];
	rw = 1'b1;
	nLds = ldsLevel;
	nAs = 1'b0;
	for (i = 0; i < 4; i++)
	begin
		@(posedge clk);
		#1;
		checkEq("dataOutEn", 64'(dataOutEn), 64'(0));
	end
	nAs = 1'b1;
	nLds = 1'b1;
	@(posedge clk);
	#1;
endtask

task automatic testDipReads();
	logic [7:0] data;
	dipSw = 8'(nextRand());
	busRead(mvsIoPkg::DIP_BASE + 24'h000001, data);
	checkEq("dataOut", 64'(data), 64'(dipSw));
	busRead(mvsIoPkg::DIP_BASE + 24'h010011, data);	// Upper half of the region, A7 clear
	checkEq("dataOut", 64'(data), 64'(dipSw));
	busRead(mvsIoPkg::DIP_BASE + 24'h000081, data);
	checkEq("dataOut", 64'(data), 64'(mvsIoPkg::SYSTYPE_VALUE));
	noResponse(24'h340001, 1'b0);	// Gap past the status region
	noResponse(mvsIoPkg::DIP_BASE + 24'h000001, 1'b1);	// Even byte only
endtask

task automatic testSlots();
	int sys;
	int s;
	int i;
	logic [5:0] expSlot;
	for (sys = 1; sys >= 0; sys--)
	begin
		systemB = sys[0];
		for (s = 0; s < 8; s++)
		begin
			busWrite(regAddr(mvsIoPkg::REG_SLOT), {5'(nextRand()), 3'(s)});
			for (i = 0; i < 6; i++)
				expSlot[i] = !(sys == 1 && s == i);	// One low select, none past 5
			checkEq("nSlot", 64'(nSlot), 64'(expSlot));
			checkEq("{slotC,slotB,slotA}", 64'({slotC, slotB, slotA}), sys == 1 ? 64'(s) : 64'(0));
		end
	end
	systemB = 1'b1;
endtask

task automatic testLeds();
	logic [2:0] latchSeq [11];
	logic [7:0] expDisp [3];
	logic [2:0] prev;
	logic [2:0] rise;
	logic [7:0] data;
	logic [31:0] fill;
	int i;
	int j;
	latchSeq = '{3'b001, 3'b000, 3'b010, 3'b000, 3'b100, 3'b000, 3'b011, 3'b111, 3'b000, 3'b111,
		3'b110};
	expDisp = '{8'h00, 8'h00, 8'h00};
	prev = 3'b000;
	for (i = 0; i < 11; i++)
	begin
		data = 8'(nextRand());
		fill = nextRand();
		busWrite(regAddr(mvsIoPkg::REG_LEDDATA), data);
		busWrite(regAddr(mvsIoPkg::REG_LEDLATCH), {fill[7:6], latchSeq[i], fill[2:0]});
		rise = latchSeq[i] & ~prev;
		for (j = 0; j < 3; j++)
			if (rise[j])
				expDisp[j] = data;
		prev = latchSeq[i];
		checkEq("elLamps", 64'(elLamps), 64'(expDisp[0]));
		checkEq("ledMarquee1", 64'(ledMarquee1), 64'(expDisp[1]));
		checkEq("ledMarquee2", 64'(ledMarquee2), 64'(expDisp[2]));
	end
endtask

task automatic testCalendarSetRead();
	mvsIoPkg::rtcTimeT written;
	mvsIoPkg::rtcTimeT got;
	written = randomTime();
	rtcSetTime(written);
	rtcReadTime(got);
	checkReadTime(written, got, timeReadCycle - timeSetCycle);
endtask

task automatic testCalendarCount();
	mvsIoPkg::rtcTimeT written;
	mvsIoPkg::rtcTimeT got;
	logic [7:0] status;
	logic lastTp;
	int toggles;
	int polls;
	written = randomTime();
	written.hours = 8'h23;
	written.minutes = 8'h59;
	written.seconds = 8'h58;
	rtcSetTime(written);
	busRead(mvsIoPkg::STATUS_BASE + 24'h1, status);
	lastTp = status[6];
	toggles = 0;
	polls = 0;
	while (toggles < 4 && polls < 64)	// Two ticks at least
	begin
		busRead(mvsIoPkg::STATUS_BASE + 24'h1, status);
		checkEq("dataOut[7]", 64'(status[7]), 64'(status[6]));	// Hold mode puts TP on dout
		if (status[6] != lastTp)
			toggles++;
		lastTp = status[6];
		polls++;
	end
	assert (toggles >= 4)
	else stopRun("TP output did not toggle within the poll limit");
	rtcReadTime(got);
	checkEq("hours", 64'(got.hours), 64'(0));
	checkEq("minutes", 64'(got.minutes), 64'(0));
	checkEq("seconds[7:4]", 64'(got.seconds[7:4]), 64'(0));
	checkReadTime(written, got, timeReadCycle - timeSetCycle);
endtask

//--- tests/mvsIoTb.sv
`timescale 1ns/100ps

module mvsIoTb;

	logic clk;
	logic nRESET;
	logic [22:0] cpuAddr;	// A23..A1
	logic nAs;
	logic rw;
	logic nLds;
	logic [7:0] dataIn;
	logic [7:0] dipSw;
	logic systemB;
	logic [7:0] dataOut;
	logic dataOutEn;
	logic [5:0] nSlot;
	logic slotA;
	logic slotB;
	logic slotC;
	logic [7:0] elLamps;
	logic [7:0] ledMarquee1;
	logic [7:0] ledMarquee2;
	logic [31:0] rngState = 32'h7816864e;
	int cycleCount = 0;
	int errorCount = 0;
	int strobeCycle;	// Cycle of the latest strobe write
	int timeSetCycle;
	int timeReadCycle;	// Strobe of the time-read snapshot

	mvsIoTop u_dut (
		.CLK_24M(clk), .nRESET(nRESET), .cpuAddr(cpuAddr), .nAs(nAs), .rw(rw), .nLds(nLds),
		.dataIn(dataIn), .dipSw(dipSw), .systemB(systemB), .dataOut(dataOut),
		.dataOutEn(dataOutEn), .nSlot(nSlot), .slotA(slotA), .slotB(slotB), .slotC(slotC),
		.elLamps(elLamps), .ledMarquee1(ledMarquee1), .ledMarquee2(ledMarquee2)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;	// LCG step
		return rngState;
	endfunction

	task automatic stopRun(input string why);
		errorCount++;
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp)
		else stopRun($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Odd byte of a register in the write block
	function automatic logic [23:0] regAddr(input logic [2:0] sel);
		return mvsIoPkg::BITW_BASE | {17'h0, sel, 4'h1};
	endfunction

	task automatic busWrite(input logic [23:0] addr, input logic [7:0] data);
		cpuAddr = addr[23:1];
		rw = 1'b0;
		nLds = 1'b0;
		dataIn = data;
		nAs = 1'b0;
		repeat (4) @(posedge clk);	// nAs held four cycles
		#1;
		nAs = 1'b1;
		nLds = 1'b1;
		rw = 1'b1;
		@(posedge clk);
		#1;
	endtask

	task automatic busRead(input logic [23:0] addr, output logic [7:0] data);
		int waitCycles;
		waitCycles = 0;
		cpuAddr = addr[23:1];
		rw = 1'b1;
		nLds = 1'b0;
		nAs = 1'b0;
		do
		begin
			@(posedge clk);
			#1;
			waitCycles++;
		end
		while (!dataOutEn && waitCycles < 8);
		assert (dataOutEn)
		else stopRun($sformatf("No read data enable for address %h", addr));
		@(posedge clk);	// Third cycle of the access
		#1;
		data = dataOut;
		nAs = 1'b1;
		nLds = 1'b1;
		@(posedge clk);
		#1;
	endtask

	// Calendar lines through the control register
	task automatic rtcLines(input logic strobe, input logic rtcClk, input logic din);
		busWrite(regAddr(mvsIoPkg::REG_RTCCTRL), {5'b00000, strobe, rtcClk, din});
	endtask

	task automatic rtcWriteBits(input logic [47:0] bits, input int count);
		int i;
		for (i = 0; i < count; i++)
		begin
			rtcLines(1'b0, 1'b0, bits[i]);	// LSB goes first
			rtcLines(1'b0, 1'b1, bits[i]);
		end
	endtask

	task automatic rtcCommand(input logic [3:0] cmd);
		rtcWriteBits({44'h0, cmd}, 4);
		rtcLines(1'b1, 1'b0, 1'b0);
		strobeCycle = cycleCount;
		rtcLines(1'b0, 1'b0, 1'b0);
	endtask

	// 48 data bits follow the command bits through the 4-bit register
	task automatic rtcSetTime(input mvsIoPkg::rtcTimeT t);
		rtcCommand(mvsIoPkg::RTC_CMD_SHIFT);
		rtcWriteBits(t, 48);
		rtcCommand(mvsIoPkg::RTC_CMD_TIMESET);
		timeSetCycle = strobeCycle;
	endtask

	task automatic rtcReadTime(output mvsIoPkg::rtcTimeT t);
		logic [7:0] status;
		logic [47:0] bits;
		int i;
		rtcCommand(mvsIoPkg::RTC_CMD_TIMEREAD);	// Snapshot, shift mode on
		timeReadCycle = strobeCycle;
		for (i = 0; i < 48; i++)
		begin
			busRead(mvsIoPkg::STATUS_BASE + 24'h1, status);
			bits[i] = status[7];	// dout on bit 7
			rtcLines(1'b0, 1'b1, 1'b0);
			rtcLines(1'b0, 1'b0, 1'b0);
		end
		rtcCommand(mvsIoPkg::RTC_CMD_HOLD);
		t = bits;
	endtask

	`include "mvsIoChecks.svh"

	initial
	begin
		nRESET = 1'b0;
		cpuAddr = '0;
		nAs = 1'b1;
		rw = 1'b1;
		nLds = 1'b1;
		dataIn = 8'h00;
		dipSw = 8'h00;
		systemB = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		nRESET = 1'b1;
		testReset();
		testDipReads();
		testSlots();
		testLeds();
		testCalendarSetRead();
		testCalendarCount();
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- hw/mvsIoTop.sv
`timescale 1ns/100ps

module mvsIoTop (
	input  logic        CLK_24M,
	input  logic        nRESET,
	input  logic [22:0] cpuAddr,
	input  logic        nAs,
	input  logic        rw,
	input  logic        nLds,
	input  logic [7:0]  dataIn,
	input  logic [7:0]  dipSw,
	input  logic        systemB,
	output logic [7:0]  dataOut,
	output logic        dataOutEn,
	output logic [5:0]  nSlot,
	output logic        slotA,
	output logic        slotB,
	output logic        slotC,
	output logic [7:0]  elLamps,
	output logic [7:0]  ledMarquee1,
	output logic [7:0]  ledMarquee2
);

	logic nDipRd0;
	logic nDipRd1;
	logic nBitWd0;
	logic [3:0] addrLow;
	logic [2:0] ledLatch;
	logic [7:0] ledData;
	logic rtcDin;
	logic rtcClk;
	logic rtcStrobe;
	logic rtcDout;
	logic rtcTp;

	ioAddrDecode u_decode (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.cpuAddr(cpuAddr), .nAs(nAs), .rw(rw), .nLds(nLds),
		.nDipRd0(nDipRd0), .nDipRd1(nDipRd1), .nBitWd0(nBitWd0), .addrLow(addrLow)
	);

	neoF0 u_neoF0 (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.nDipRd0(nDipRd0), .nDipRd1(nDipRd1), .nBitWd0(nBitWd0), .addrLow(addrLow),
		.dataIn(dataIn), .dipSw(dipSw), .systemB(systemB),
		.rtcDout(rtcDout), .rtcTp(rtcTp),
		.dataOut(dataOut), .dataOutEn(dataOutEn),
		.nSlot(nSlot), .slotA(slotA), .slotB(slotB), .slotC(slotC),
		.ledLatch(ledLatch), .ledData(ledData),
		.rtcDin(rtcDin), .rtcClk(rtcClk), .rtcStrobe(rtcStrobe)
	);

	// Calendar chip on the three bit-banged lines
	rtcCalendar u_rtc (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.rtcDin(rtcDin), .rtcClk(rtcClk), .rtcStrobe(rtcStrobe),
		.rtcDout(rtcDout), .rtcTp(rtcTp)
	);

	ledDriver u_led (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.ledLatch(ledLatch), .ledData(ledData),
		.elLamps(elLamps), .ledMarquee1(ledMarquee1), .ledMarquee2(ledMarquee2)
	);

endmodule

//--- hw/ledDriver.sv
`timescale 1ns/100ps

module ledDriver (
	input  logic       CLK_24M,
	input  logic       nRESET,
	input  logic [2:0] ledLatch,	// Rising bit loads a display
	input  logic [7:0] ledData,
	output logic [7:0] elLamps,
	output logic [7:0] ledMarquee1,
	output logic [7:0] ledMarquee2
);

	logic [2:0] latchPrev;
	logic [2:0] latchRise;
	logic [2:0][7:0] display;	// Index matches latch bit

	assign latchRise = ledLatch & ~latchPrev;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			latchPrev <= 3'b000;
			display <= '0;
		end
		else
		begin
			latchPrev <= ledLatch;
			// Several bits may rise in the same write
			for (int i = 0; i < 3; i++)
			begin
				if (latchRise[i])
					display[i] <= ledData;
			end
		end
	end

	assign elLamps = display[0];
	assign ledMarquee1 = display[1];
	assign ledMarquee2 = display[2];

endmodule

//--- hw/rtcCalendar.sv
`timescale 1ns/100ps

module rtcCalendar (
	input  logic CLK_24M,
	input  logic nRESET,
	input  logic rtcDin,
	input  logic rtcClk,
	input  logic rtcStrobe,
	output logic rtcDout,
	output logic rtcTp
);

	logic dinS;
	logic clkS;
	logic strobeS;
	logic clkD;
	logic strobeD;
	logic clkRise;
	logic strobeRise;
	logic [3:0] cmdReg;
	logic shiftMode;	// Low for hold
	logic timeSet;
	logic timeRead;
	mvsIoPkg::rtcWordT dataWord;
	mvsIoPkg::rtcTimeT calTime;
	logic [mvsIoPkg::RTC_TICK_W-1:0] tickCnt;
	logic tick;
	logic tpReg;
	logic [8:0] secNext;	// {carry, BCD}
	logic [8:0] minNext;
	logic [8:0] hourNext;

	// BCD step with wrap at last
	function automatic logic [8:0] bcdInc(input logic [7:0] value, input logic [7:0] last);
		logic [7:0] stepped;
		if (value == last)
			return {1'b1, 8'h00};
		if (value[3:0] == 4'd9)
			stepped = {value[7:4] + 4'd1, 4'd0};
		else
			stepped = {value[7:4], value[3:0] + 4'd1};
		return {1'b0, stepped};
	endfunction

	function automatic logic bcdOk(input logic [7:0] value);
		return value[7:4] <= 4'd9 && value[3:0] <= 4'd9;
	endfunction

	// Input sync and edge detect
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			dinS <= 1'b0;
			clkS <= 1'b0;
			strobeS <= 1'b0;
			clkD <= 1'b0;
			strobeD <= 1'b0;
		end
		else
		begin
			dinS <= rtcDin;
			clkS <= rtcClk;
			strobeS <= rtcStrobe;
			clkD <= clkS;
			strobeD <= strobeS;
		end
	end

	assign clkRise = clkS && !clkD;
	assign strobeRise = strobeS && !strobeD;
	assign timeSet = strobeRise && cmdReg == mvsIoPkg::RTC_CMD_TIMESET;
	assign timeRead = strobeRise && cmdReg == mvsIoPkg::RTC_CMD_TIMEREAD;

	assign tick = tickCnt == mvsIoPkg::RTC_TICK_LAST;
	assign secNext = bcdInc(calTime.seconds, 8'h59);
	assign minNext = bcdInc(calTime.minutes, 8'h59);
	assign hourNext = bcdInc(calTime.hours, 8'h23);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			cmdReg <= mvsIoPkg::RTC_CMD_HOLD;
			shiftMode <= 1'b0;
			calTime <= '0;
			tickCnt <= '0;
			tpReg <= 1'b0;
		end
		else
		begin
			// Divider restarts on time set
			if (timeSet)
			begin
				tickCnt <= '0;
				tpReg <= 1'b0;
			end
			else
			begin
				tickCnt <= tick ? '0 : tickCnt + 1'b1;
				if (tick || tickCnt == mvsIoPkg::RTC_TICK_MID)
					tpReg <= !tpReg;	// Half-second square wave
			end

			// Time counter, carries stop at hours
			if (timeSet)
				calTime <= dataWord.fields;
			else if (tick)
			begin
				calTime.seconds <= secNext[7:0];
				if (secNext[8])
				begin
					calTime.minutes <= minNext[7:0];
					if (minNext[8])
						calTime.hours <= hourNext[7:0];
				end
			end

			if (clkRise)
				cmdReg <= {dinS, cmdReg[3:1]};	// New bit enters at the top

			if (strobeRise)
			begin
				case (cmdReg)
					mvsIoPkg::RTC_CMD_HOLD:     shiftMode <= 1'b0;
					mvsIoPkg::RTC_CMD_SHIFT:    shiftMode <= 1'b1;
					mvsIoPkg::RTC_CMD_TIMESET:  shiftMode <= 1'b0;
					mvsIoPkg::RTC_CMD_TIMEREAD: shiftMode <= 1'b1;
					default:                    ;	// Test modes not modelled
				endcase
			end
		end
	end

	// Data shift chain
	// Command bit 0 feeds the data word, bit 0 of the data word leaves on dout
	always_ff @(posedge CLK_24M)
	begin
		if (timeRead)
			dataWord.fields <= calTime;
		else if (clkRise && shiftMode)
			dataWord.raw <= {cmdReg[0], dataWord.raw[47:1]};
	end

	assign rtcDout = shiftMode ? dataWord.raw[0] : tpReg;
	assign rtcTp = tpReg;

	timeBcdOk: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		calTime.seconds < 8'h60 && calTime.minutes < 8'h60 && calTime.hours < 8'h24
		&& bcdOk(calTime.seconds) && bcdOk(calTime.minutes) && bcdOk(calTime.hours)
		&& bcdOk(calTime.day) && bcdOk(calTime.year));

endmodule

//--- hw/neoF0.sv
`timescale 1ns/100ps

module neoF0 (
	input  logic       CLK_24M,
	input  logic       nRESET,
	input  logic       nDipRd0,
	input  logic       nDipRd1,	// Status A read
	input  logic       nBitWd0,
	input  logic [3:0] addrLow,	// A7..A4
	input  logic [7:0] dataIn,
	input  logic [7:0] dipSw,
	input  logic       systemB,
	input  logic       rtcDout,
	input  logic       rtcTp,
	output logic [7:0] dataOut,
	output logic       dataOutEn,
	output logic [5:0] nSlot,
	output logic       slotA,
	output logic       slotB,
	output logic       slotC,
	output logic [2:0] ledLatch,
	output logic [7:0] ledData,
	output logic       rtcDin,
	output logic       rtcClk,
	output logic       rtcStrobe
);

	logic [2:0] slotReg;
	logic [2:0] rtcCtrl;	// {strobe, clk, din}

	assign rtcDin = rtcCtrl[0];
	assign rtcClk = rtcCtrl[1];
	assign rtcStrobe = rtcCtrl[2];

	// Control registers
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			slotReg <= 3'b000;
			ledLatch <= 3'b000;
			rtcCtrl <= 3'b000;
		end
		else if (!nBitWd0)
		begin
			case (addrLow[2:0])
				mvsIoPkg::REG_SLOT:
					slotReg <= dataIn[2:0];
				mvsIoPkg::REG_LEDLATCH:
					ledLatch <= dataIn[5:3];	// Three latch enables sit mid-byte
				mvsIoPkg::REG_RTCCTRL:
					rtcCtrl <= dataIn[2:0];
				default:
					;	// LED data and unused selects
			endcase
		end
	end

	// LED data byte
	always_ff @(posedge CLK_24M)
	begin
		if (!nBitWd0 && addrLow[2:0] == mvsIoPkg::REG_LEDDATA)
			ledData <= dataIn;
	end

	// Read data mux
	always_comb
	begin
		dataOutEn = !nDipRd0 || !nDipRd1;
		if (!nDipRd0)
			dataOut = addrLow[3] ? mvsIoPkg::SYSTYPE_VALUE : dipSw;	// A7 picks system type
		else if (!nDipRd1)
			dataOut = {rtcDout, rtcTp, 6'b111111};	// Coin and test inputs read idle
		else
			dataOut = 8'h00;
	end

	// Slot select
	// Shifting past bit 5 leaves zero, so codes 6 and 7 give all ones
	assign nSlot = systemB ? ~(6'b000001 << slotReg) : 6'b111111;
	assign {slotC, slotB, slotA} = systemB ? slotReg : 3'b000;	// Single-slot boards tie low

	rdSelExcl: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!(!nDipRd0 && !nDipRd1));

endmodule

//--- hw/ioAddrDecode.sv
`timescale 1ns/100ps

module ioAddrDecode (
	input  logic        CLK_24M,
	input  logic        nRESET,
	input  logic [22:0] cpuAddr,	// A23..A1
	input  logic        nAs,
	input  logic        rw,		// High for read
	input  logic        nLds,	// Odd byte lane
	output logic        nDipRd0,
	output logic        nDipRd1,
	output logic        nBitWd0,
	output logic [3:0]  addrLow	// A7..A4
);

	logic [6:0] regionBits;
	logic byteAccess;
	logic dipHit;
	logic statusHit;
	logic bitwHit;
	logic cycleTaken;	// Bus cycle already seen since nAs fell

	assign regionBits = cpuAddr[22:16];	// A23..A17
	assign byteAccess = !nAs && !nLds;

	// Region compares
	assign dipHit = byteAccess && rw && (regionBits == mvsIoPkg::DIP_BASE[23:17]);
	assign statusHit = byteAccess && rw && (regionBits == mvsIoPkg::STATUS_BASE[23:17]);
	assign bitwHit = byteAccess && !rw && (regionBits == mvsIoPkg::BITW_BASE[23:17]);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			nDipRd0 <= 1'b1;
			nDipRd1 <= 1'b1;
			nBitWd0 <= 1'b1;
			cycleTaken <= 1'b0;
		end
		else
		begin
			nDipRd0 <= !dipHit;	// Levels, held while the CPU holds nAs
			nDipRd1 <= !statusHit;
			nBitWd0 <= !(bitwHit && !cycleTaken);	// One pulse per nAs assertion
			if (nAs)
				cycleTaken <= 1'b0;
			else if (byteAccess)
				cycleTaken <= 1'b1;
		end
	end

	// Low address bits captured on the first edge of the cycle
	always_ff @(posedge CLK_24M)
	begin
		if (byteAccess && !cycleTaken)
			addrLow <= cpuAddr[6:3];
	end

	// Regions never overlap
	selOneHot: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$onehot0({!nDipRd0, !nDipRd1, !nBitWd0}));

endmodule

//--- hw/mvsIoPkg.sv
package mvsIoPkg;

	// 68000 byte address regions
	// Each one spans 128 KB, so only A23..A17 take part in the match
	localparam logic [23:0] DIP_BASE    = 24'h300000;	// DIP switches, system type
	localparam logic [23:0] STATUS_BASE = 24'h320000;	// Status A, calendar bits on top
	localparam logic [23:0] BITW_BASE   = 24'h380000;	// Write-only register block

	// Register selects on A6..A4 inside the BITW region
	localparam logic [2:0] REG_SLOT     = 3'd2;	// $380021
	localparam logic [2:0] REG_LEDLATCH = 3'd3;	// $380031
	localparam logic [2:0] REG_LEDDATA  = 3'd4;	// $380041
	localparam logic [2:0] REG_RTCCTRL  = 3'd5;	// $380051

	// Returned for DIP region reads with A7 set
	localparam logic [7:0] SYSTYPE_VALUE = 8'h80;

	// Calendar commands as shifted into the 4-bit command register
	localparam logic [3:0] RTC_CMD_HOLD     = 4'd0;
	localparam logic [3:0] RTC_CMD_SHIFT    = 4'd1;
	localparam logic [3:0] RTC_CMD_TIMESET  = 4'd2;
	localparam logic [3:0] RTC_CMD_TIMEREAD = 4'd3;

	// One calendar second in CLK_24M cycles
	// Kept short on purpose so the clock moves within a simulation run
	localparam int RTC_TICK_CYCLES = 16;
	localparam int RTC_TICK_W = $clog2(RTC_TICK_CYCLES);

	// Divider compare points
	localparam logic [RTC_TICK_W-1:0] RTC_TICK_LAST = RTC_TICK_W'(RTC_TICK_CYCLES - 1);
	localparam logic [RTC_TICK_W-1:0] RTC_TICK_MID  = RTC_TICK_W'(RTC_TICK_CYCLES / 2 - 1);

	// Calendar time word, MSB first as it leaves the shift register last
	typedef struct packed {
		logic [7:0] year;	// BCD
		logic [3:0] month;	// Binary 1..12
		logic [3:0] weekday;
		logic [7:0] day;	// BCD
		logic [7:0] hours;	// BCD, 00..23
		logic [7:0] minutes;	// BCD
		logic [7:0] seconds;	// BCD
	} rtcTimeT;

	// Same 48 bits seen either as time fields or as the raw shift chain
	typedef union packed {
		rtcTimeT fields;
		logic [47:0] raw;
	} rtcWordT;

endpackage
